/* forth_proc.f */
rtl/forth_pkg.sv
rtl/stack_if.sv
rtl/boot_rom.sv
rtl/data_stack.sv
rtl/uart_tx.sv
rtl/forth_core.sv
rtl/forth_top.sv
testbench/forth_top_checker.sv
testbench/tb_forth_top.sv

/* rtl/boot_rom.sv */
// boot rom: threaded program with inline operands, combinational read
`default_nettype none

module boot_rom (
  input  forth_pkg::rom_addr_t rom_addr,
  output forth_pkg::word_t     rom_data
);

  ////////////////////
  // program
  ////////////////////
  always_comb begin
    // empty slots decode as nop
    rom_data = forth_pkg::word_t'(forth_pkg::op_nop);
    case (rom_addr)
      // print "?" once
      6'd0:  rom_data = forth_pkg::word_t'(forth_pkg::op_lit);
      6'd1:  rom_data = 32'd63;
      6'd2:  rom_data = forth_pkg::word_t'(forth_pkg::op_emit);
      // main loop, buttons to leds and to serial as a digit
      6'd3:  rom_data = forth_pkg::word_t'(forth_pkg::op_io_button);
      6'd4:  rom_data = forth_pkg::word_t'(forth_pkg::op_dup);
      6'd5:  rom_data = forth_pkg::word_t'(forth_pkg::op_io_led);
      6'd6:  rom_data = forth_pkg::word_t'(forth_pkg::op_lit);
      6'd7:  rom_data = 32'd48;
      6'd8:  rom_data = forth_pkg::word_t'(forth_pkg::op_plus);
      6'd9:  rom_data = forth_pkg::word_t'(forth_pkg::op_emit);
      // short countdown
      6'd10: rom_data = forth_pkg::word_t'(forth_pkg::op_lit);
      6'd11: rom_data = 32'd3;
      6'd12: rom_data = forth_pkg::word_t'(forth_pkg::op_lit);
      6'd13: rom_data = 32'd1;
      6'd14: rom_data = forth_pkg::word_t'(forth_pkg::op_minus);
      6'd15: rom_data = forth_pkg::word_t'(forth_pkg::op_dup);
      6'd16: rom_data = forth_pkg::word_t'(forth_pkg::op_zero_equal);
      6'd17: rom_data = forth_pkg::word_t'(forth_pkg::op_zero_branch);
      6'd18: rom_data = 32'd12;
      // discard spent count, next pass
      6'd19: rom_data = forth_pkg::word_t'(forth_pkg::op_drop);
      6'd20: rom_data = forth_pkg::word_t'(forth_pkg::op_branch);
      6'd21: rom_data = 32'd3;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/data_stack.sv */
// data stack as a circular word array with one action per clock and tos/nos exposed
`default_nettype none

module data_stack (
  input  logic    clk,
  input  logic    reset,
  stack_if.stack  stk
);

  // stack entries
  forth_pkg::word_t mem [forth_pkg::stack_depth];

  // points at the current top and wraps both ways
  logic [$clog2(forth_pkg::stack_depth)-1:0] sp;

  ////////////////////
  // read side
  ////////////////////
  assign stk.tos = mem[sp];
  assign stk.nos = mem[sp - 1'b1];

  ////////////////////
  // pointer
  ////////////////////
  always_ff @(posedge clk) begin
    if (!reset) begin
      sp <= '0;
    end else begin
      case (stk.op)
        forth_pkg::stk_push:        sp <= sp + 1'b1;
        forth_pkg::stk_pop,
        forth_pkg::stk_pop_replace: sp <= sp - 1'b1;
        default: ;
      endcase
    end
  end

  // entry writes
  always_ff @(posedge clk) begin
    case (stk.op)
      forth_pkg::stk_push:        mem[sp + 1'b1] <= stk.wdata;
      forth_pkg::stk_replace:     mem[sp] <= stk.wdata;
      // lands on the entry that becomes top
      forth_pkg::stk_pop_replace: mem[sp - 1'b1] <= stk.wdata;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/forth_core.sv */
// forth core: fetch/execute sequencer with led, button and emit control
`default_nettype none

module forth_core (
  input  logic                 clk,
  input  logic                 reset,
  output forth_pkg::rom_addr_t rom_addr,
  input  forth_pkg::word_t     rom_data,
  stack_if.core                stk,
  output logic                 tx_start,
  output logic [7:0]           tx_byte,
  input  logic                 tx_busy,
  input  logic                 button0,
  input  logic                 button1,
  output logic                 led_g,
  output logic                 led_b,
  output logic                 led_r
);

  forth_pkg::core_state_e state, state_next;
  forth_pkg::rom_addr_t   pc, pc_next;
  // current instruction
  forth_pkg::op_e         ir;

  // active low leds, bit 0 green, 1 blue, 2 red
  logic [forth_pkg::led_w-1:0]    led_reg;
  logic                           led_we;
  // two stage button synchronizer
  logic [forth_pkg::button_w-1:0] btn_meta;
  logic [forth_pkg::button_w-1:0] btn_sync;

  // pc already sits on the operand during execute
  assign rom_addr = pc;
  assign tx_byte  = stk.tos[7:0];
  assign led_g    = led_reg[0];
  assign led_b    = led_reg[1];
  assign led_r    = led_reg[2];

  ////////////////////
  // decode
  ////////////////////
  always_comb begin
    stk.op     = forth_pkg::stk_none;
    stk.wdata  = '0;
    tx_start   = 1'b0;
    led_we     = 1'b0;
    pc_next    = pc;
    state_next = forth_pkg::st_fetch;
    if (state == forth_pkg::st_fetch) begin
      pc_next    = pc + 1'b1;
      state_next = forth_pkg::st_execute;
    end else begin
      case (ir)
        forth_pkg::op_lit: begin
          // push inline word, step over it
          stk.op    = forth_pkg::stk_push;
          stk.wdata = rom_data;
          pc_next   = pc + 1'b1;
        end
        forth_pkg::op_plus: begin
          stk.op    = forth_pkg::stk_pop_replace;
          stk.wdata = stk.nos + stk.tos;
        end
        forth_pkg::op_minus: begin
          stk.op    = forth_pkg::stk_pop_replace;
          stk.wdata = stk.nos - stk.tos;
        end
        forth_pkg::op_dup: begin
          stk.op    = forth_pkg::stk_push;
          stk.wdata = stk.tos;
        end
        forth_pkg::op_drop: stk.op = forth_pkg::stk_pop;
        forth_pkg::op_zero_equal: begin
          // forth true is all ones
          stk.op    = forth_pkg::stk_replace;
          stk.wdata = (stk.tos == '0) ? '1 : '0;
        end
        forth_pkg::op_branch: pc_next = rom_data[forth_pkg::rom_addr_w-1:0];
        forth_pkg::op_zero_branch: begin
          // flag consumed either way
          stk.op  = forth_pkg::stk_pop;
          pc_next = (stk.tos == '0) ? rom_data[forth_pkg::rom_addr_w-1:0] : pc + 1'b1;
        end
        forth_pkg::op_io_led: begin
          stk.op = forth_pkg::stk_pop;
          led_we = 1'b1;
        end
        forth_pkg::op_io_button: begin
          stk.op    = forth_pkg::stk_push;
          stk.wdata = forth_pkg::word_t'(btn_sync);
        end
        forth_pkg::op_emit: begin
          // hold here until transmitter is idle
          if (tx_busy) begin
            state_next = forth_pkg::st_execute;
          end else begin
            tx_start = 1'b1;
            stk.op   = forth_pkg::stk_pop;
          end
        end
        default: ;
      endcase
    end
  end

  ////////////////////
  // registers
  ////////////////////
  always_ff @(posedge clk) begin
    if (!reset) begin
      state    <= forth_pkg::st_fetch;
      pc       <= '0;
      led_reg  <= '1;
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      state    <= state_next;
      pc       <= pc_next;
      btn_meta <= {button1, button0};
      btn_sync <= btn_meta;
      if (led_we) begin
        led_reg <= ~stk.tos[forth_pkg::led_w-1:0];
      end
    end
  end

  // opcode lives in the low byte
  always_ff @(posedge clk) begin
    if (state == forth_pkg::st_fetch) begin
      ir <= forth_pkg::op_e'(rom_data[7:0]);
    end
  end

endmodule

`default_nettype wire

/* rtl/forth_pkg.sv */
// forth package: sizes, serial timing, word types and the core enums
`default_nettype none

package forth_pkg;

  ////////////////////
  // sizes
  ////////////////////
  localparam int data_w      = 32;
  localparam int rom_addr_w  = 6;
  localparam int stack_depth = 16;
  localparam int led_w       = 3;
  localparam int button_w    = 2;

  // 12 MHz / 625 gives 19200 baud
  localparam int clks_per_bit = 625;

  typedef logic [data_w-1:0]     word_t;
  typedef logic [rom_addr_w-1:0] rom_addr_t;

  ////////////////////
  // enums
  ////////////////////
  // opcodes used by the boot program
  typedef enum logic [7:0] {
    op_nop, op_lit, op_plus, op_minus, op_dup, op_drop, op_zero_equal,
    op_branch, op_zero_branch, op_io_led, op_io_button, op_emit
  } op_e;

  // inner interpreter states
  typedef enum logic [1:0] {
    st_fetch, st_execute
  } core_state_e;

  // one stack action per clock
  typedef enum logic [2:0] {
    stk_none, stk_push, stk_pop, stk_replace, stk_pop_replace
  } stack_op_e;

endpackage

`default_nettype wire

/* rtl/forth_top.sv */
// forth top: boot rom, data stack, core and serial transmitter
`default_nettype none

module forth_top (
  input  logic clk,
  input  logic reset,
  input  logic button0,
  input  logic button1,
  output logic tx,
  output logic led_g,
  output logic led_b,
  output logic led_r
);

  forth_pkg::rom_addr_t rom_addr;
  forth_pkg::word_t     rom_data;
  // core to transmitter
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;

  stack_if stk_bus ();

  boot_rom u_boot_rom (
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

  data_stack u_data_stack (
    .clk   (clk),
    .reset (reset),
    .stk   (stk_bus.stack)
  );

  forth_core u_forth_core (
    .clk      (clk),
    .reset    (reset),
    .rom_addr (rom_addr),
    .rom_data (rom_data),
    .stk      (stk_bus.core),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .button0  (button0),
    .button1  (button1),
    .led_g    (led_g),
    .led_b    (led_b),
    .led_r    (led_r)
  );

  uart_tx #(
    .clks_per_bit (forth_pkg::clks_per_bit)
  ) u_uart_tx (
    .clk      (clk),
    .reset    (reset),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

endmodule

`default_nettype wire

/* rtl/stack_if.sv */
// data stack bus: operation and write word in, top and second entries out
`default_nettype none

interface stack_if;

  // requested action, applied on next edge
  forth_pkg::stack_op_e op;
  forth_pkg::word_t     wdata;
  // current top of stack and next on stack
  forth_pkg::word_t     tos;
  forth_pkg::word_t     nos;

  // sequencer side
  modport core (output op, output wdata, input tos, input nos);

  // storage side
  modport stack (input op, input wdata, output tos, output nos);

endinterface

`default_nettype wire

/* rtl/uart_tx.sv */
// uart transmitter: start bit, 8 data bits lsb first, stop bit
`default_nettype none

module uart_tx #(
  parameter int clks_per_bit = forth_pkg::clks_per_bit
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx
);

  // clocks within current bit
  logic [$clog2(clks_per_bit)-1:0] clk_cnt;
  // 0 start, 1..8 data, 9 stop
  logic [3:0] bit_cnt;
  // byte plus stop bit, shifted out lsb first
  logic [8:0] shreg;
  logic       bit_end;

  assign bit_end = (clk_cnt == $bits(clk_cnt)'(clks_per_bit - 1));

  ////////////////////
  // frame control
  ////////////////////
  always_ff @(posedge clk) begin
    if (!reset) begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!tx_busy) begin
      // idle, line high
      if (tx_start) begin
        tx_busy <= 1'b1;
        tx      <= 1'b0;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        // stop bit done, tx already high
        tx_busy <= 1'b0;
      end else begin
        tx      <= shreg[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // shifter, ones fill in behind the byte
  always_ff @(posedge clk) begin
    if (tx_start && !tx_busy) begin
      shreg <= {1'b1, tx_byte};
    end else if (tx_busy && bit_end && bit_cnt != 4'd9) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the forth processor simulation with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_forth_top -f forth_proc.f
./obj_dir/Vtb_forth_top +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi

/* testbench/forth_top_checker.sv */
// forth top checker: idle leds, red led, tx validity and minimum low time on tx
`default_nettype none

module forth_top_checker (
  input logic clk,
  input logic reset,
  input logic tx,
  input logic led_g,
  input logic led_b,
  input logic led_r
);
  timeunit 1ns;
  timeprecision 1ps;

  // failure counts, one per assertion
  int unsigned fails_idle = 0;
  int unsigned fails_red = 0;
  int unsigned fails_x = 0;
  int unsigned fails_low = 0;

  // set by the first low on tx
  logic        started;
  // consecutive cycles with tx low
  logic [15:0] low_run;

  always_ff @(posedge clk) begin
    if (!reset) begin
      started <= 1'b0;
      low_run <= '0;
    end else begin
      if (!tx) begin
        started <= 1'b1;
      end
      if (tx) begin
        low_run <= '0;
      end else if (low_run != '1) begin
        low_run <= low_run + 1'b1;
      end
    end
  end

  ////////////////////
  // assertions
  ////////////////////
  idle_dark: assert property (@(posedge clk) disable iff (!reset)
    (!started && tx) |-> (led_g && led_b && led_r))
    else begin
      $error("leds lit before the first start bit");
      fails_idle++;
    end

  // red is never driven by the program
  red_off: assert property (@(posedge clk) disable iff (!reset) led_r)
    else begin
      $error("led_r went low");
      fails_red++;
    end

  tx_known: assert property (@(posedge clk) disable iff (!reset) !$isunknown(tx))
    else begin
      $error("tx is unknown");
      fails_x++;
    end

  // any low stretch on tx spans at least one bit period
  low_full_bit: assert property (@(posedge clk) disable iff (!reset)
    $rose(tx) |-> (low_run >= 16'(forth_pkg::clks_per_bit)))
    else begin
      $error("tx low for less than one bit period");
      fails_low++;
    end

endmodule

bind forth_top forth_top_checker u_checker (
  .clk   (clk),
  .reset (reset),
  .tx    (tx),
  .led_g (led_g),
  .led_b (led_b),
  .led_r (led_r)
);

`default_nettype wire

/* testbench/tb_forth_top.sv */
// forth top testbench checking greeting, button echo, led display and loop stability
`default_nettype none

module tb_forth_top;
  timeunit 1ns;
  timeprecision 1ps;

  // one row per button pattern
  typedef struct packed {
    logic [forth_pkg::button_w-1:0] buttons;
    logic [7:0]                     exp_byte;
    // {led_r, led_b, led_g} active low
    logic [forth_pkg::led_w-1:0]    exp_leds;
  } vector_t;

  logic clk = 1'b0;
  logic reset;
  logic button0;
  logic button1;
  logic tx;
  logic led_g;
  logic led_b;
  logic led_r;

  vector_t    vectors [4];
  logic [7:0] rx;
  int         value_errors = 0;
  int         frame_errors = 0;
  int         assert_errors = 0;
  // set once a wait runs out so later steps are skipped
  bit         aborted = 1'b0;

  forth_top u_forth_top (
    .clk     (clk),
    .reset   (reset),
    .button0 (button0),
    .button1 (button1),
    .tx      (tx),
    .led_g   (led_g),
    .led_b   (led_b),
    .led_r   (led_r)
  );

  // 25 MHz
  always #20 clk = ~clk;

  ////////////////////
  // compare tasks
  ////////////////////
  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0d ns: %s, got 8'h%h expected 8'h%h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_leds(input logic [forth_pkg::led_w-1:0] got,
                            input logic [forth_pkg::led_w-1:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
      value_errors++;
    end
  endtask

  // drive both buttons just after a rising edge
  task automatic set_buttons(input logic [forth_pkg::button_w-1:0] value);
    @(posedge clk);
    #1;
    button0 = value[0];
    button1 = value[1];
  endtask

  ////////////////////
  // serial receiver
  ////////////////////
  // returns in the middle of the stop bit
  task automatic receive_byte(output logic [7:0] data, input bit idle_check);
    int waited;
    data = 8'h00;
    waited = 0;
    if (aborted) begin
      return;
    end
    @(negedge clk);
    while (tx !== 1'b0 && waited < 20 * forth_pkg::clks_per_bit) begin
      if (idle_check) begin
        check_leds({led_r, led_b, led_g}, '1, "leds before first frame");
      end
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0) begin
      $display("no start bit seen within %0d clock cycles", waited);
      frame_errors++;
      aborted = 1'b1;
      return;
    end
    // start bit holds for one full period
    for (int i = 1; i < forth_pkg::clks_per_bit; i++) begin
      @(negedge clk);
      if (tx !== 1'b0) begin
        $display("start bit ended after only %0d clock cycles", i);
        frame_errors++;
        aborted = 1'b1;
        return;
      end
    end
    // on to mid bit 0 and then one period per bit
    repeat (forth_pkg::clks_per_bit / 2 + 1) @(negedge clk);
    for (int b = 0; b < 8; b++) begin
      data[b] = tx;
      repeat (forth_pkg::clks_per_bit) @(negedge clk);
    end
    if (tx !== 1'b1) begin
      $display("stop bit was low at %0d ns", $time);
      frame_errors++;
    end
  endtask

  ////////////////////
  // sequence
  ////////////////////
  initial begin
    // ascii digit of the button value and inverted leds
    vectors[0] = '{2'b01, 8'h31, 3'b110};
    vectors[1] = '{2'b10, 8'h32, 3'b101};
    vectors[2] = '{2'b00, 8'h30, 3'b111};
    vectors[3] = '{2'b11, 8'h33, 3'b100};

    reset = 1'b0;
    // nonzero buttons make an early led write visible
    button0 = 1'b1;
    button1 = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b1;

    // "?" comes first
    receive_byte(rx, 1'b1);
    check_byte(rx, 8'h3f, "greeting");

    foreach (vectors[i]) begin
      if (!aborted) begin
        set_buttons(vectors[i].buttons);
        // this frame was read with the old buttons
        receive_byte(rx, 1'b0);
        receive_byte(rx, 1'b0);
        check_byte(rx, vectors[i].exp_byte, $sformatf("echo of pattern %0d", i));
        check_leds({led_r, led_b, led_g}, vectors[i].exp_leds,
                   $sformatf("leds for pattern %0d", i));
      end
    end

    // steady loop without drift across passes
    set_buttons(2'b11);
    receive_byte(rx, 1'b0);
    for (int n = 0; n < 5; n++) begin
      receive_byte(rx, 1'b0);
      check_byte(rx, 8'd48 + 8'd3, $sformatf("loop frame %0d", n));
    end

    assert_errors = u_forth_top.u_checker.fails_idle + u_forth_top.u_checker.fails_red
                  + u_forth_top.u_checker.fails_x + u_forth_top.u_checker.fails_low;
    $display("errors: %0d value, %0d frame, %0d assertion",
             value_errors, frame_errors, assert_errors);
    if (value_errors + frame_errors + assert_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
